//--- source/tpuPackage.sv
// Pipeline-side data word and commit token types, referenced by scoped name from the load path
`default_nettype none

package tpuPackage;

	////////////////////////////////////////////////////////////
	// Data path

	typedef logic [31:0] dataT;		// One vector element

	localparam int dataDepth = 16;	// Data ring buffer entries

	////////////////////////////////////////////////////////////
	// Commit tokens

	// Travels with a request and comes back to commit in request order
	typedef struct packed {
		logic [4:0] destination;	// Destination register index
		logic [3:0] tag;			// Pipeline tag
	} tokenT;

endpackage

`default_nettype wire

//--- source/memoryPackage.sv
// Scratchpad address type, memory sizes and the queued access record for the strided load path
`default_nettype none

package memoryPackage;

	typedef logic [7:0] addressT;		// Word address, wraps modulo depth

	localparam int memoryDepth = 256;	// Scratchpad words
	localparam int queueDepth = 8;		// Pending access requests

	// One strided access as it waits in the request queue
	typedef struct packed {
		addressT base;					// First word address
		addressT stride;				// Address step per word
		addressT length;				// Word count, at least one
		tpuPackage::tokenT token;		// Released on the last word
	} accessT;

endpackage

`default_nettype wire

//--- source/accessBus.sv
// Strided access request, grant, return stream and hold between the load unit and memory port
`timescale 1ns/1ps
`default_nettype none

interface accessBus;

	logic request;						// Level, head waiting for issue
	memoryPackage::addressT base;
	memoryPackage::addressT stride;
	memoryPackage::addressT length;
	logic grant;						// Pulse, fields captured here
	logic valid;						// One word per strobe
	tpuPackage::dataT data;
	logic term;							// Marks the last word
	logic hold;							// Pauses the walker

	modport unit (
		output request, base, stride, length, hold,
		input grant, valid, data, term
	);

	modport memory (
		input request, base, stride, length, hold,
		output grant, valid, data, term
	);

endinterface

`default_nettype wire

//--- source/ringBuffer.sv
// Circular FIFO with a type-parameterized payload, used for load data and for queued requests
`timescale 1ns/1ps
`default_nettype none

module ringBuffer #(
	parameter int entries = 16,
	parameter type payloadT = logic [31:0]
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic write,
	input wire payloadT writeData,
	input wire logic read,
	output payloadT readData,
	output logic full,
	output logic empty,
	output logic [$clog2(entries):0] count
);

	payloadT storage [entries];
	logic [$clog2(entries)-1:0] writePointer;
	logic [$clog2(entries)-1:0] readPointer;
	logic writeEnable;
	logic readEnable;

	assign writeEnable = write & ~full;		// Drop writes when full
	assign readEnable = read & ~empty;		// Drop reads when empty

	assign full = (count == ($clog2(entries) + 1)'(entries));
	assign empty = (count == '0);
	assign readData = storage[readPointer];	// Head shown without a read

	always_ff @(posedge clock) begin
		if (writeEnable) begin
			storage[writePointer] <= writeData;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			writePointer <= '0;
			readPointer <= '0;
			count <= '0;
		end else begin
			if (writeEnable) begin
				writePointer <= (int'(writePointer) == entries - 1) ? '0 : writePointer + 1'b1;
			end
			if (readEnable) begin
				readPointer <= (int'(readPointer) == entries - 1) ? '0 : readPointer + 1'b1;
			end
			if (writeEnable & ~readEnable) begin
				count <= count + 1'b1;
			end else if (readEnable & ~writeEnable) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/accessQueue.sv
// Queues access requests with their tokens, issues the head to memory and retires it on term
`timescale 1ns/1ps
`default_nettype none

module accessQueue (
	input wire logic clock,
	input wire logic reset,
	input wire logic push,
	input wire memoryPackage::accessT entry,
	output logic full,
	accessBus.unit bus,
	output logic tokenValid,
	output tpuPackage::tokenT tokenOut
);

	memoryPackage::accessT head;
	logic empty;
	logic running;					// Head access is being streamed

	////////////////////////////////////////////////////////////
	// Pending requests

	ringBuffer #(
		.entries(memoryPackage::queueDepth),
		.payloadT(memoryPackage::accessT)
	) requestBuffer (
		.clock(clock),
		.reset(reset),
		.write(push),
		.writeData(entry),
		.read(bus.term),			// Retire head with its last word
		.readData(head),
		.full(full),
		.empty(empty),
		.count()
	);

	////////////////////////////////////////////////////////////
	// Issue

	always_ff @(posedge clock) begin
		if (reset) begin
			running <= 1'b0;
		end else if (bus.term) begin
			running <= 1'b0;
		end else if (bus.grant) begin
			running <= 1'b1;
		end
	end

	// Only one access in flight at a time
	assign bus.request = ~empty & ~running;
	assign bus.base = head.base;
	assign bus.stride = head.stride;
	assign bus.length = head.length;

	////////////////////////////////////////////////////////////
	// Token release

	assign tokenValid = bus.term;
	assign tokenOut = tokenValid ? head.token : '0;	// Zero between releases

endmodule

`default_nettype wire

//--- source/ldstUnit.sv
// Load unit that buffers the returning stream, paces commit reads and releases commit tokens
`timescale 1ns/1ps
`default_nettype none

module ldstUnit (
	input wire logic clock,
	input wire logic reset,
	input wire logic push,
	input wire memoryPackage::accessT entry,
	output logic stall,
	accessBus.unit bus,
	input wire logic commitGrant,
	output logic dataValid,
	output tpuPackage::dataT data,
	output logic tokenValid,
	output tpuPackage::tokenT tokenOut
);

	tpuPackage::dataT headData;
	logic dataFull;
	logic dataEmpty;
	logic queueFull;

	////////////////////////////////////////////////////////////
	// Return data

	ringBuffer #(
		.entries(tpuPackage::dataDepth),
		.payloadT(tpuPackage::dataT)
	) dataBuffer (
		.clock(clock),
		.reset(reset),
		.write(bus.valid),			// Every streamed word
		.writeData(bus.data),
		.read(dataValid),
		.readData(headData),
		.full(dataFull),
		.empty(dataEmpty),
		.count()
	);

	assign bus.hold = dataFull;		// Pause memory when no room

	// Commit sees the oldest word only while it grants
	assign dataValid = ~dataEmpty & commitGrant;
	assign data = dataValid ? headData : '0;

	////////////////////////////////////////////////////////////
	// Requests and tokens

	accessQueue requestQueue (
		.clock(clock),
		.reset(reset),
		.push(push),
		.entry(entry),
		.full(queueFull),
		.bus(bus),
		.tokenValid(tokenValid),
		.tokenOut(tokenOut)
	);

	assign stall = queueFull;		// Issue stage must wait

endmodule

`default_nettype wire

//--- source/stridedMemory.sv
// Scratchpad memory port with a preload write and a strided walker that streams words under hold
`timescale 1ns/1ps
`default_nettype none

module stridedMemory (
	input wire logic clock,
	input wire logic reset,
	accessBus.memory bus,
	input wire logic memWrite,
	input wire memoryPackage::addressT memAddress,
	input wire tpuPackage::dataT memWriteData
);

	tpuPackage::dataT storage [memoryPackage::memoryDepth];

	logic active;						// Walker busy with an access
	memoryPackage::addressT current;	// Address of the next word
	memoryPackage::addressT stepSize;
	memoryPackage::addressT remaining;	// Words still to send

	////////////////////////////////////////////////////////////
	// Scratchpad

	always_ff @(posedge clock) begin
		if (memWrite) begin
			storage[memAddress] <= memWriteData;	// Preload from outside
		end
	end

	////////////////////////////////////////////////////////////
	// Walker

	assign bus.grant = bus.request & ~active;	// Accept whenever idle

	always_ff @(posedge clock) begin
		if (reset) begin
			active <= 1'b0;
		end else if (bus.grant) begin
			active <= 1'b1;
		end else if (bus.term) begin
			active <= 1'b0;
		end
	end

	// Fields captured at the grant edge
	always_ff @(posedge clock) begin
		if (bus.grant) begin
			current <= bus.base;
			stepSize <= bus.stride;
			remaining <= bus.length;
		end else if (bus.valid) begin
			current <= current + stepSize;	// Wraps modulo 256
			remaining <= remaining - 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Return stream

	assign bus.valid = active & ~bus.hold;	// No step while held
	assign bus.term = bus.valid & (remaining == 8'd1);
	assign bus.data = storage[current];

endmodule

`default_nettype wire

//--- source/loadStoreTop.sv
// Top level of the strided load path; connects the load unit to the scratchpad port
`timescale 1ns/1ps
`default_nettype none

module loadStoreTop (
	input wire logic clock,
	input wire logic reset,
	input wire logic request,
	input wire memoryPackage::addressT base,
	input wire memoryPackage::addressT stride,
	input wire memoryPackage::addressT length,
	input wire tpuPackage::tokenT token,
	output logic stall,
	input wire logic commitGrant,
	output logic dataValid,
	output tpuPackage::dataT data,
	output logic tokenValid,
	output tpuPackage::tokenT tokenOut,
	input wire logic memWrite,
	input wire memoryPackage::addressT memAddress,
	input wire tpuPackage::dataT memWriteData
);

	memoryPackage::accessT entry;
	logic push;

	accessBus memoryBus ();

	assign push = request & ~stall;		// Accepted only without stall
	assign entry = '{base: base, stride: stride, length: length, token: token};

	ldstUnit loadUnit (
		.clock(clock),
		.reset(reset),
		.push(push),
		.entry(entry),
		.stall(stall),
		.bus(memoryBus.unit),
		.commitGrant(commitGrant),
		.dataValid(dataValid),
		.data(data),
		.tokenValid(tokenValid),
		.tokenOut(tokenOut)
	);

	stridedMemory scratchpad (
		.clock(clock),
		.reset(reset),
		.bus(memoryBus.memory),
		.memWrite(memWrite),
		.memAddress(memAddress),
		.memWriteData(memWriteData)
	);

endmodule

`default_nettype wire

//--- tests/loadStoreTb.sv
// Random-stimulus testbench for the strided load path, checked against a scratchpad and queue model
`timescale 1ns/1ps
`default_nettype none

module loadStoreTb;

	localparam int requestCount = 40;
	localparam int maxLength = 12;
	localparam int preloadCycles = 256;
	localparam int clockPeriod = 10;

	logic clock;
	logic reset;
	logic request;
	memoryPackage::addressT base;
	memoryPackage::addressT stride;
	memoryPackage::addressT length;
	tpuPackage::tokenT token;
	logic stall;
	logic commitGrant;
	logic dataValid;
	tpuPackage::dataT data;
	logic tokenValid;
	tpuPackage::tokenT tokenOut;
	logic memWrite;
	memoryPackage::addressT memAddress;
	tpuPackage::dataT memWriteData;

	tpuPackage::dataT scratch [memoryPackage::memoryDepth];	// Model of the scratchpad
	memoryPackage::addressT reqBase [requestCount];
	memoryPackage::addressT reqStride [requestCount];
	memoryPackage::addressT reqLength [requestCount];
	tpuPackage::tokenT reqToken [requestCount];
	tpuPackage::dataT expWords [$];
	tpuPackage::tokenT expTokens [$];
	int tokenEnds [$];				// Cumulative word count at each request's end
	int totalWords = 0;
	int submitted = 0;
	int submittedWords = 0;
	int committed = 0;
	int tokensSeen = 0;
	logic [31:0] rngState = 32'h8485346e;

	loadStoreTop loadStoreTop_i (.*);

	always #(clockPeriod / 2) clock = ~clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] value);
		value = value ^ (value << 13);
		value = value ^ (value >> 17);
		value = value ^ (value << 5);
		return value;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	task automatic compare(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1);
	endtask

	// Long stretches with no commit, then a random grant per cycle
	function automatic logic grantPattern(input int cycle);
		if (cycle % 64 < 30) begin
			return 1'b0;
		end
		return 1'(nextRandom() & 1);
	endfunction

	task automatic issueRequest(input int index);
		int k;
		request = 1'b1;
		base = reqBase[index];
		stride = reqStride[index];
		length = reqLength[index];
		token = reqToken[index];
		for (k = 0; k < int'(reqLength[index]); k++) begin	// Word k at base plus k times stride
			expWords.push_back(scratch[(int'(reqBase[index]) + k * int'(reqStride[index]))
				% memoryPackage::memoryDepth]);
		end
		submittedWords += int'(reqLength[index]);
		tokenEnds.push_back(submittedWords);
		expTokens.push_back(reqToken[index]);
		submitted++;
	endtask

	////////////////////////////////////////////////////////////
	// Output monitor, sampled mid-cycle

	always @(negedge clock) begin
		if (!reset) begin
			if (!commitGrant) begin
				compare("dataValid", dataValid, 32'd0);
				compare("data", data, 32'd0);
			end
			if (tokenValid) begin
				if (expTokens.size() == 0) begin
					abortRun("A token was released with no request pending");
				end else begin
					compare("tokenOut", tokenOut, expTokens.pop_front());
					// Last word must already fit in the buffer behind the committed ones
					if (committed + tpuPackage::dataDepth < tokenEnds.pop_front()) begin
						abortRun("A token was released before its last word was buffered");
					end
					tokensSeen++;
				end
			end
			if (dataValid) begin
				if (expWords.size() == 0) begin
					abortRun("dataValid was high with no word expected");
				end else begin
					compare("data", data, expWords.pop_front());
					committed++;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Watchdog

	initial begin
		wait (totalWords != 0);
		#((20 * totalWords + preloadCycles) * clockPeriod);
		abortRun("Timeout: the load stream did not drain in time");
	end

	////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		int cycle;
		int index;
		int selector;
		tpuPackage::dataT value;
		clock = 1'b0;
		reset = 1'b1;
		request = 1'b0;
		base = '0;
		stride = '0;
		length = '0;
		token = '0;
		commitGrant = 1'b1;		// Granted so an unreset buffer would show dataValid
		memWrite = 1'b0;
		memAddress = '0;
		memWriteData = '0;
		for (index = 0; index < requestCount; index++) begin
			selector = (index < 2) ? index : int'(nextRandom() % 8);
			reqBase[index] = 8'(nextRandom());
			case (selector)
				0: reqStride[index] = 8'd0;			// Same word repeated
				1: reqStride[index] = 8'd255;		// Walks backward
				default: reqStride[index] = 8'(nextRandom());
			endcase
			reqLength[index] = 8'(1 + nextRandom() % maxLength);
			reqToken[index] = 9'(nextRandom());
			totalWords += int'(reqLength[index]);
		end
		repeat (4) @(posedge clock);
		#1 reset = 1'b0;
		@(negedge clock);
		compare("stall", stall, 32'd0);
		compare("dataValid", dataValid, 32'd0);
		compare("tokenValid", tokenValid, 32'd0);
		for (index = 0; index < preloadCycles; index++) begin
			@(posedge clock);
			#1;
			value = nextRandom();
			memWrite = 1'b1;
			memAddress = 8'(index);
			memWriteData = value;
			scratch[index] = value;
		end
		@(posedge clock);
		#1 memWrite = 1'b0;
		index = 0;
		cycle = 0;
		while (index < requestCount) begin
			@(posedge clock);
			#1;
			request = 1'b0;
			commitGrant = grantPattern(cycle);
			compare("stall", stall, 32'((submitted - tokensSeen) == memoryPackage::queueDepth));
			if (!stall && (nextRandom() % 4 != 0)) begin
				issueRequest(index);
				index++;
			end
			cycle++;
		end
		while (expWords.size() != 0 || expTokens.size() != 0) begin
			@(posedge clock);
			#1;
			request = 1'b0;
			commitGrant = 1'(nextRandom() & 1);
		end
		commitGrant = 1'b1;
		repeat (5) @(posedge clock);
		@(negedge clock);
		compare("stall", stall, 32'd0);		// Queue drained
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
source/tpuPackage.sv
source/memoryPackage.sv
source/accessBus.sv
source/ringBuffer.sv
source/accessQueue.sv
source/ldstUnit.sv
source/stridedMemory.sv
source/loadStoreTop.sv
tests/loadStoreTb.sv
